// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_subsystem_tb
FILELIST  ?= dcache_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= simulate.log
PASS_TEXT ?= Testbench passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dcache_subsystem.f ====
source/dcache_pkg.sv
source/line_store.sv
source/miss_tracker.sv
source/miss_control.sv
source/dcache_subsystem.sv
tests/clock_gen.sv
tests/dcache_subsystem_asserts.sv
tests/dcache_subsystem_tb.sv

// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // Cache and tracker geometry
    localparam int line_count      = 8;
    localparam int line_index_bits = 3;
    localparam int mshr_depth      = 4;
    localparam int mshr_index_bits = 2;

    // Address and data sizes
    localparam int mem_tag_bits  = 4;
    localparam int addr_bits     = 32;
    localparam int word_bits     = 32;
    localparam int line_bytes    = 8;
    localparam int line_words    = 2;
    localparam int offset_bits   = 3;
    localparam int line_tag_bits = addr_bits - offset_bits;

    typedef logic [addr_bits-1:0]     addr_t;
    typedef logic [word_bits-1:0]     word_t;
    typedef logic [line_tag_bits-1:0] line_tag_t;
    typedef logic [mem_tag_bits-1:0]  mem_tag_t;
    typedef logic [line_bytes-1:0]    byte_enable_t;

    // Memory tag zero marks an idle data return
    localparam mem_tag_t no_tag = '0;

    // One line, addressed by byte or by word
    typedef union packed {
        logic [line_bytes-1:0][7:0]          bytes;
        logic [line_words-1:0][word_bits-1:0] words;
    } line_data_t;

    typedef struct packed {
        logic      valid;
        line_tag_t line_tag;
    } line_request_t;

    typedef struct packed {
        logic       valid;
        line_data_t data;
    } read_result_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;
        line_tag_t  line_tag;
        line_data_t data;
    } cache_line_t;

    typedef struct packed {
        logic       valid;
        line_tag_t  line_tag;
        line_data_t data;
    } writeback_t;

    typedef struct packed {
        logic       valid;
        line_tag_t  line_tag;
        line_data_t data;
    } refill_t;

    // Store word already placed in its half of the line
    typedef struct packed {
        logic         valid;
        line_tag_t    line_tag;
        line_data_t   data;
        byte_enable_t byte_enable;
    } store_update_t;

    typedef struct packed {
        logic      valid;
        mem_tag_t  mem_tag;
        line_tag_t line_tag;
    } mshr_entry_t;

endpackage

`default_nettype wire

// ==== source/dcache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem (
    input  logic                      clock,
    input  logic                      reset,
    input  dcache_pkg::line_request_t load_request,
    output dcache_pkg::read_result_t  load_result,
    input  logic                      store_valid,
    input  dcache_pkg::addr_t         store_addr,
    input  dcache_pkg::word_t         store_data,
    output logic                      store_response,
    output dcache_pkg::line_request_t mem_request,
    input  logic                      mem_accepted,
    input  dcache_pkg::mem_tag_t      accepted_tag,
    input  dcache_pkg::line_data_t    mem_data,
    input  dcache_pkg::mem_tag_t      mem_data_tag,
    output dcache_pkg::writeback_t    mem_write
);

    dcache_pkg::line_request_t store_lookup;
    logic                      store_hit;
    dcache_pkg::store_update_t store_update;
    dcache_pkg::refill_t       refill;
    dcache_pkg::writeback_t    eviction;
    dcache_pkg::line_tag_t     snoop;
    logic                      snoop_found;
    dcache_pkg::mshr_entry_t   new_entry;

    line_store line_store_i (
        .clock        (clock),
        .reset        (reset),
        .load_request (load_request),
        .load_result  (load_result),
        .store_lookup (store_lookup),
        .store_hit    (store_hit),
        .store_update (store_update),
        .refill       (refill),
        .eviction     (eviction)
    );

    miss_tracker miss_tracker_i (
        .clock        (clock),
        .reset        (reset),
        .snoop        (snoop),
        .snoop_found  (snoop_found),
        .new_entry    (new_entry),
        .mem_data_tag (mem_data_tag),
        .mem_data     (mem_data),
        .refill       (refill)
    );

    miss_control miss_control_i (
        .store_valid    (store_valid),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .store_response (store_response),
        .load_request   (load_request),
        .load_result    (load_result),
        .store_hit      (store_hit),
        .refill         (refill),
        .eviction       (eviction),
        .snoop_found    (snoop_found),
        .mem_accepted   (mem_accepted),
        .accepted_tag   (accepted_tag),
        .store_lookup   (store_lookup),
        .store_update   (store_update),
        .snoop          (snoop),
        .mem_request    (mem_request),
        .mem_write      (mem_write),
        .new_entry      (new_entry)
    );

endmodule

`default_nettype wire

// ==== source/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  logic                      clock,
    input  logic                      reset,
    input  dcache_pkg::line_request_t load_request,
    output dcache_pkg::read_result_t  load_result,
    input  dcache_pkg::line_request_t store_lookup,
    output logic                      store_hit,
    input  dcache_pkg::store_update_t store_update,
    input  dcache_pkg::refill_t       refill,
    output dcache_pkg::writeback_t    eviction
);

    dcache_pkg::cache_line_t [dcache_pkg::line_count-1:0] lines;
    logic [dcache_pkg::line_index_bits-1:0]               victim_ptr;

    // Store lookup result
    logic [dcache_pkg::line_index_bits-1:0] hit_index;

    // Lowest invalid line for refill placement
    logic                                   free_found;
    logic [dcache_pkg::line_index_bits-1:0] free_index;

    // Single write port into the line array
    logic                                   write_enable;
    logic [dcache_pkg::line_index_bits-1:0] write_index;
    dcache_pkg::cache_line_t                write_line;
    dcache_pkg::line_data_t                 merged_data;
    logic                                   victim_advance;

    // Load port, all tags compared at once
    always_comb begin
        load_result = '0;
        for (int i = 0; i < dcache_pkg::line_count; i++) begin
            if (load_request.valid && lines[i].valid &&
                lines[i].line_tag == load_request.line_tag) begin
                load_result.valid = 1'b1;
                load_result.data  = lines[i].data;
            end
        end
    end

    // Store hit test
    always_comb begin
        store_hit = 1'b0;
        hit_index = '0;
        for (int i = 0; i < dcache_pkg::line_count; i++) begin
            if (store_lookup.valid && lines[i].valid &&
                lines[i].line_tag == store_lookup.line_tag) begin
                store_hit = 1'b1;
                hit_index = dcache_pkg::line_index_bits'(i);
            end
        end
    end

    // Walk downwards so the lowest free line wins
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = dcache_pkg::line_count - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                free_found = 1'b1;
                free_index = dcache_pkg::line_index_bits'(i);
            end
        end
    end

    // Byte merge of the store into the hit line
    always_comb begin
        merged_data = lines[hit_index].data;
        for (int b = 0; b < dcache_pkg::line_bytes; b++) begin
            if (store_update.byte_enable[b]) begin
                merged_data.bytes[b] = store_update.data.bytes[b];
            end
        end
    end

    // Refill first, then store update
    always_comb begin
        write_enable   = 1'b0;
        write_index    = '0;
        write_line     = '0;
        victim_advance = 1'b0;
        eviction       = '0;
        if (refill.valid) begin
            write_enable = 1'b1;
            write_line   = '{valid: 1'b1, dirty: 1'b0,
                             line_tag: refill.line_tag, data: refill.data};
            if (free_found) begin
                write_index = free_index;
            end else begin
                write_index    = victim_ptr;
                victim_advance = 1'b1;
                // Clean victim is simply dropped
                eviction.valid    = lines[victim_ptr].valid && lines[victim_ptr].dirty;
                eviction.line_tag = lines[victim_ptr].line_tag;
                eviction.data     = lines[victim_ptr].data;
            end
        end else if (store_update.valid && store_hit) begin
            write_enable = 1'b1;
            write_index  = hit_index;
            write_line   = '{valid: 1'b1, dirty: 1'b1,
                             line_tag: store_update.line_tag, data: merged_data};
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            victim_ptr <= '0;
            for (int i = 0; i < dcache_pkg::line_count; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else begin
            if (write_enable) begin
                lines[write_index] <= write_line;
            end
            // Rotating victim, moves only when a full cache is refilled
            if (victim_advance) begin
                if (victim_ptr == dcache_pkg::line_index_bits'(dcache_pkg::line_count - 1)) begin
                    victim_ptr <= '0;
                end else begin
                    victim_ptr <= victim_ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/miss_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_control (
    input  logic                      store_valid,
    input  dcache_pkg::addr_t         store_addr,
    input  dcache_pkg::word_t         store_data,
    output logic                      store_response,
    input  dcache_pkg::line_request_t load_request,
    input  dcache_pkg::read_result_t  load_result,
    input  logic                      store_hit,
    input  dcache_pkg::refill_t       refill,
    input  dcache_pkg::writeback_t    eviction,
    input  logic                      snoop_found,
    input  logic                      mem_accepted,
    input  dcache_pkg::mem_tag_t      accepted_tag,
    output dcache_pkg::line_request_t store_lookup,
    output dcache_pkg::store_update_t store_update,
    output dcache_pkg::line_tag_t     snoop,
    output dcache_pkg::line_request_t mem_request,
    output dcache_pkg::writeback_t    mem_write,
    output dcache_pkg::mshr_entry_t   new_entry
);

    dcache_pkg::line_tag_t store_tag;
    logic                  word_select;
    logic                  miss_valid;
    dcache_pkg::line_tag_t miss_tag;

    // Address bit 2 picks the word within the 8-byte line
    assign store_tag   = store_addr[dcache_pkg::addr_bits-1:dcache_pkg::offset_bits];
    assign word_select = store_addr[dcache_pkg::offset_bits-1];

    // Refill owns the write port this cycle, so the store retries
    assign store_response = store_valid && store_hit && !refill.valid;

    always_comb begin
        store_lookup.valid    = store_valid;
        store_lookup.line_tag = store_tag;
    end

    always_comb begin
        store_update          = '0;
        store_update.valid    = store_response;
        store_update.line_tag = store_tag;
        store_update.data.words[word_select] = store_data;
        store_update.byte_enable = word_select ? 8'hf0 : 8'h0f;
    end

    // Store miss ahead of load miss
    always_comb begin
        miss_valid = 1'b0;
        miss_tag   = store_tag;
        if (store_valid && !store_hit) begin
            miss_valid = 1'b1;
            miss_tag   = store_tag;
        end else if (load_request.valid && !load_result.valid) begin
            miss_valid = 1'b1;
            miss_tag   = load_request.line_tag;
        end
    end

    assign snoop = miss_tag;

    // Eviction only carries dirty victims
    assign mem_write = eviction;

    // Writeback wins the memory port, duplicates are held back
    always_comb begin
        mem_request.valid    = miss_valid && !mem_write.valid && !snoop_found;
        mem_request.line_tag = miss_tag;
    end

    always_comb begin
        new_entry.valid    = mem_request.valid && mem_accepted &&
                             (accepted_tag != dcache_pkg::no_tag);
        new_entry.mem_tag  = accepted_tag;
        new_entry.line_tag = mem_request.line_tag;
    end

endmodule

`default_nettype wire

// ==== source/miss_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_tracker (
    input  logic                    clock,
    input  logic                    reset,
    input  dcache_pkg::line_tag_t   snoop,
    output logic                    snoop_found,
    input  dcache_pkg::mshr_entry_t new_entry,
    input  dcache_pkg::mem_tag_t    mem_data_tag,
    input  dcache_pkg::line_data_t  mem_data,
    output dcache_pkg::refill_t     refill
);

    dcache_pkg::mshr_entry_t [dcache_pkg::mshr_depth-1:0] entries;
    logic [dcache_pkg::mshr_index_bits-1:0]               head;
    logic [dcache_pkg::mshr_index_bits-1:0]               tail;
    logic                                                 pop;

    // Duplicate check against every outstanding request
    always_comb begin
        snoop_found = 1'b0;
        for (int i = 0; i < dcache_pkg::mshr_depth; i++) begin
            if (entries[i].valid && entries[i].line_tag == snoop) begin
                snoop_found = 1'b1;
            end
        end
    end

    // Returns arrive in order, so only the head can match
    assign pop = (mem_data_tag != dcache_pkg::no_tag) && entries[head].valid &&
                 (entries[head].mem_tag == mem_data_tag);

    always_comb begin
        refill.valid    = pop;
        refill.line_tag = entries[head].line_tag;
        refill.data     = mem_data;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < dcache_pkg::mshr_depth; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                if (head == dcache_pkg::mshr_index_bits'(dcache_pkg::mshr_depth - 1)) begin
                    head <= '0;
                end else begin
                    head <= head + 1'b1;
                end
            end
            // No full check here, the core side keeps within mshr_depth
            if (new_entry.valid) begin
                entries[tail] <= new_entry;
                if (tail == dcache_pkg::mshr_index_bits'(dcache_pkg::mshr_depth - 1)) begin
                    tail <= '0;
                end else begin
                    tail <= tail + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clock
);

    // 8 ns period
    localparam realtime half_period = 4.0;

    initial begin
        clock = 1'b0;
        forever begin
            #(half_period);
            clock = ~clock;
        end
    end

endmodule

`default_nettype wire

// ==== tests/dcache_subsystem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem_asserts (
    input logic                      clock,
    input logic                      reset,
    input logic                      store_response,
    input dcache_pkg::line_request_t mem_request,
    input logic                      mem_accepted,
    input dcache_pkg::mem_tag_t      accepted_tag,
    input dcache_pkg::mem_tag_t      mem_data_tag,
    input dcache_pkg::writeback_t    mem_write,
    input dcache_pkg::mshr_entry_t   new_entry
);

    int         failure_count = 0;
    logic [3:0] outstanding;

    // Accepted requests minus tagged returns
    always_ff @(posedge clock) begin
        if (!reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding
                + 4'(mem_request.valid && mem_accepted && accepted_tag != '0)
                - 4'(mem_data_tag != '0);
        end
    end

    // Writebacks only leave with a line return that evicts
    writeback_on_refill: assert property (@(posedge clock) disable iff (!reset)
        mem_write.valid |-> mem_data_tag != '0)
    else begin
        failure_count = failure_count + 1;
        $error("memory write without a line return");
    end

    // A line return owns the line array, so no store completes beside a writeback
    store_not_beside_writeback: assert property (@(posedge clock) disable iff (!reset)
        store_response |-> !mem_write.valid)
    else begin
        failure_count = failure_count + 1;
        $error("store completed in a cycle with a memory write");
    end

    // Recorded line is held back from the next request
    tracked_line_not_requested: assert property (@(posedge clock) disable iff (!reset)
        new_entry.valid |=> !(mem_request.valid &&
                              mem_request.line_tag == $past(new_entry.line_tag)))
    else begin
        failure_count = failure_count + 1;
        $error("memory request repeated for a line already tracked");
    end

    tracker_not_overfilled: assert property (@(posedge clock) disable iff (!reset)
        outstanding <= 4'(dcache_pkg::mshr_depth))
    else begin
        failure_count = failure_count + 1;
        $error("more outstanding memory requests than tracker entries");
    end

endmodule

`default_nettype wire

// ==== tests/dcache_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem_tb;

    localparam int clock_period    = 8;
    localparam int reset_cycles    = 16;
    localparam int request_timeout = 20;
    // Six tests with a reset each and seventeen line transfers of a few cycles
    localparam int transfer_count  = 17;
    localparam int transfer_cycles = 8;
    localparam int test_cycles     = 6 * (reset_cycles + 10) + transfer_count * transfer_cycles;
    localparam int watchdog_ns     = 2 * test_cycles * clock_period;

    logic                      clock;
    logic                      reset;
    dcache_pkg::line_request_t load_request;
    dcache_pkg::read_result_t  load_result;
    logic                      store_valid;
    dcache_pkg::addr_t         store_addr;
    dcache_pkg::word_t         store_data;
    logic                      store_response;
    dcache_pkg::line_request_t mem_request;
    logic                      mem_accepted;
    dcache_pkg::mem_tag_t      accepted_tag;
    dcache_pkg::line_data_t    mem_data;
    dcache_pkg::mem_tag_t      mem_data_tag;
    dcache_pkg::writeback_t    mem_write;

    // Memory model state
    dcache_pkg::mem_tag_t next_tag;
    dcache_pkg::mem_tag_t pending_tags[$];
    logic [15:0]          lfsr_state;

    clock_gen clock_gen_i (
        .clock (clock)
    );

    dcache_subsystem dcache_subsystem_i (.*);

    bind dcache_subsystem dcache_subsystem_asserts asserts_i (
        .clock          (clock),
        .reset          (reset),
        .store_response (store_response),
        .mem_request    (mem_request),
        .mem_accepted   (mem_accepted),
        .accepted_tag   (accepted_tag),
        .mem_data_tag   (mem_data_tag),
        .mem_write      (mem_write),
        .new_entry      (new_entry)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic dcache_pkg::line_data_t merge_word(input dcache_pkg::line_data_t line,
                                                          input dcache_pkg::addr_t addr,
                                                          input dcache_pkg::word_t word);
        logic [63:0] bits;
        bits = line;
        // Address bit 2 picks the upper word
        if (addr[2]) begin
            bits[63:32] = word;
        end else begin
            bits[31:0] = word;
        end
        return bits;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_read_result(input string name, input dcache_pkg::read_result_t expected,
                                     input dcache_pkg::read_result_t actual);
        // Data only counts on a hit
        if (expected.valid !== actual.valid ||
            (expected.valid && expected.data !== actual.data)) begin
            stop_with_failure($sformatf("FAILED at %0t: %s expected %h, actual %h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_line_request(input string name,
                                      input dcache_pkg::line_request_t expected,
                                      input dcache_pkg::line_request_t actual);
        if (expected.valid !== actual.valid ||
            (expected.valid && expected.line_tag !== actual.line_tag)) begin
            stop_with_failure($sformatf("FAILED at %0t: %s expected %h, actual %h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_writeback(input string name, input dcache_pkg::writeback_t expected,
                                   input dcache_pkg::writeback_t actual);
        if (expected.valid !== actual.valid || (expected.valid &&
            (expected.line_tag !== actual.line_tag || expected.data !== actual.data))) begin
            stop_with_failure($sformatf("FAILED at %0t: %s expected %h, actual %h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_response(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("FAILED at %0t: %s expected %b, actual %b",
                                        $time, name, expected, actual));
        end
    endtask

    // Drive point 1 ns after the rising edge
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic sample();
        @(negedge clock);
    endtask

    task automatic apply_reset();
        reset        = 1'b0;
        load_request = '0;
        store_valid  = 1'b0;
        store_addr   = '0;
        store_data   = '0;
        mem_accepted = 1'b0;
        accepted_tag = '0;
        mem_data     = '0;
        mem_data_tag = '0;
        pending_tags.delete();
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b1;
    endtask

    task automatic random_line(output dcache_pkg::line_data_t data);
        logic [63:0] bits;
        for (int i = 0; i < 64; i++) begin
            bits[i]    = lfsr_state[15];
            lfsr_state = lfsr_next(lfsr_state);
        end
        data = bits;
    endtask

    task automatic accept_request(input dcache_pkg::line_tag_t line_tag);
        int                        waited;
        dcache_pkg::line_request_t expected;
        waited   = 0;
        expected = '{valid: 1'b1, line_tag: line_tag};
        sample();
        while (!mem_request.valid) begin
            if (waited == request_timeout) begin
                stop_with_failure($sformatf("no memory request appeared for line %h", line_tag));
            end
            waited++;
            step();
            sample();
        end
        check_line_request("mem_request", expected, mem_request);
        step();
        mem_accepted = 1'b1;
        accepted_tag = next_tag;
        pending_tags.push_back(next_tag);
        // Tag zero means no tag, so wrap to one
        next_tag = (next_tag == '1) ? 4'd1 : next_tag + 1'b1;
        step();
        mem_accepted = 1'b0;
        accepted_tag = '0;
    endtask

    task automatic start_return(output dcache_pkg::line_data_t data);
        if (pending_tags.size() == 0) begin
            stop_with_failure("data return attempted with no outstanding memory request");
        end
        random_line(data);
        mem_data     = data;
        mem_data_tag = pending_tags.pop_front();
    endtask

    task automatic end_return();
        mem_data     = '0;
        mem_data_tag = '0;
    endtask

    task automatic fill_line(input dcache_pkg::line_tag_t line_tag,
                             output dcache_pkg::line_data_t data);
        load_request = '{valid: 1'b1, line_tag: line_tag};
        accept_request(line_tag);
        load_request = '0;
        start_return(data);
        step();
        end_return();
    endtask

    task automatic check_load(input dcache_pkg::line_tag_t line_tag, input logic hit,
                              input dcache_pkg::line_data_t data);
        dcache_pkg::read_result_t expected;
        expected     = '{valid: hit, data: data};
        load_request = '{valid: 1'b1, line_tag: line_tag};
        sample();
        check_read_result("load_result", expected, load_result);
        step();
        load_request = '0;
    endtask

    task automatic store_word(input dcache_pkg::addr_t addr, input dcache_pkg::word_t word,
                              input logic response);
        store_valid = 1'b1;
        store_addr  = addr;
        store_data  = word;
        sample();
        check_response("store_response", response, store_response);
        step();
        store_valid = 1'b0;
    endtask

    task automatic load_miss_refill();
        dcache_pkg::line_tag_t  line_tag;
        dcache_pkg::line_data_t data;
        line_tag = 29'h0000100;
        apply_reset();
        load_request = '{valid: 1'b1, line_tag: line_tag};
        sample();
        check_read_result("load_result", '0, load_result);
        accept_request(line_tag);
        // Load still held while the request is tracked
        sample();
        check_line_request("mem_request", '0, mem_request);
        step();
        start_return(data);
        step();
        end_return();
        check_load(line_tag, 1'b1, data);
    endtask

    task automatic store_hit_merge();
        dcache_pkg::line_tag_t  line_tag;
        dcache_pkg::line_data_t data;
        line_tag = 29'h0000200;
        apply_reset();
        fill_line(line_tag, data);
        store_word({line_tag, 3'b100}, 32'hcafe_0001, 1'b1);
        check_load(line_tag, 1'b1, merge_word(data, {line_tag, 3'b100}, 32'hcafe_0001));
    endtask

    task automatic store_miss_retry();
        dcache_pkg::line_tag_t  store_tag;
        dcache_pkg::line_data_t data;
        store_tag = 29'h0000300;
        apply_reset();
        store_valid  = 1'b1;
        store_addr   = {store_tag, 3'b000};
        store_data   = 32'h1234_5678;
        load_request = '{valid: 1'b1, line_tag: 29'h0000301};
        sample();
        check_response("store_response", 1'b0, store_response);
        // Store miss wins over the load miss
        accept_request(store_tag);
        load_request = '0;
        start_return(data);
        step();
        end_return();
        store_word({store_tag, 3'b000}, 32'h1234_5678, 1'b1);
        check_load(store_tag, 1'b1, merge_word(data, {store_tag, 3'b000}, 32'h1234_5678));
    endtask

    task automatic store_during_refill();
        dcache_pkg::line_tag_t  hit_tag;
        dcache_pkg::line_tag_t  miss_tag;
        dcache_pkg::line_data_t hit_data;
        dcache_pkg::line_data_t miss_data;
        hit_tag  = 29'h0000400;
        miss_tag = 29'h0000401;
        apply_reset();
        fill_line(hit_tag, hit_data);
        load_request = '{valid: 1'b1, line_tag: miss_tag};
        accept_request(miss_tag);
        load_request = '0;
        start_return(miss_data);
        store_word({hit_tag, 3'b000}, 32'h0bad_f00d, 1'b0);
        end_return();
        store_word({hit_tag, 3'b000}, 32'h0bad_f00d, 1'b1);
        check_load(hit_tag, 1'b1, merge_word(hit_data, {hit_tag, 3'b000}, 32'h0bad_f00d));
        check_load(miss_tag, 1'b1, miss_data);
    endtask

    task automatic dirty_eviction();
        dcache_pkg::line_tag_t  base;
        dcache_pkg::line_data_t filled[10];
        dcache_pkg::line_data_t merged;
        dcache_pkg::writeback_t expected;
        base = 29'h0002000;
        apply_reset();
        for (int i = 0; i < dcache_pkg::line_count; i++) begin
            fill_line(base + dcache_pkg::line_tag_t'(i), filled[i]);
        end
        store_word({base, 3'b100}, 32'hdead_beef, 1'b1);
        merged   = merge_word(filled[0], {base, 3'b100}, 32'hdead_beef);
        expected = '{valid: 1'b1, line_tag: base, data: merged};
        // First overflow replaces dirty line 0 while another untracked load misses
        load_request = '{valid: 1'b1, line_tag: base + 29'd8};
        accept_request(base + 29'd8);
        load_request = '{valid: 1'b1, line_tag: base + 29'd9};
        start_return(filled[8]);
        sample();
        check_writeback("mem_write", expected, mem_write);
        check_line_request("mem_request", '0, mem_request);
        step();
        end_return();
        // Second overflow replaces clean line 1
        accept_request(base + 29'd9);
        load_request = '0;
        start_return(filled[9]);
        sample();
        check_writeback("mem_write", '0, mem_write);
        step();
        end_return();
        check_load(base, 1'b0, '0);
        check_load(base + 29'd1, 1'b0, '0);
        check_load(base + 29'd2, 1'b1, filled[2]);
        check_load(base + 29'd8, 1'b1, filled[8]);
        check_load(base + 29'd9, 1'b1, filled[9]);
    endtask

    task automatic two_outstanding_misses();
        dcache_pkg::line_data_t first_data;
        dcache_pkg::line_data_t second_data;
        apply_reset();
        load_request = '{valid: 1'b1, line_tag: 29'h0000500};
        accept_request(29'h0000500);
        load_request = '{valid: 1'b1, line_tag: 29'h0000600};
        accept_request(29'h0000600);
        load_request = '0;
        start_return(first_data);
        step();
        end_return();
        start_return(second_data);
        step();
        end_return();
        check_load(29'h0000500, 1'b1, first_data);
        check_load(29'h0000600, 1'b1, second_data);
    endtask

    initial begin
        lfsr_state = 16'd54188;
        next_tag   = 4'd1;
        load_miss_refill();
        store_hit_merge();
        store_miss_retry();
        store_during_refill();
        dirty_eviction();
        two_outstanding_misses();
        if (dcache_subsystem_i.asserts_i.failure_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_with_failure("bound assertions reported errors during the run");
        end
    end

    initial begin
        #(watchdog_ns);
        stop_with_failure("watchdog timeout, the tests did not finish in time");
    end

endmodule

`default_nettype wire
